//--- floor_pkg.sv
// Floor numbering and sweep timing; index zero is the first floor and only eleven floors exist
`default_nettype none

package floor_pkg;

    ////////////////////////////////////////
    // Building geometry
    ////////////////////////////////////////

    // Floors served by the car
    localparam int num_floors = 11;

    // Zero based floor index, codes eleven to fifteen are never used
    typedef logic [3:0] floor_t;

    // One lamp or request bit per floor, bit zero is the first floor
    typedef logic [num_floors-1:0] floor_mask_t;

    ////////////////////////////////////////
    // Sweep control
    ////////////////////////////////////////

    // Idle cycles with nothing found in the current direction before
    // the sweep turns around
    localparam int sweep_wait_cycles = 11;

endpackage

`default_nettype wire

//--- car_pkg.sv
// Button, car status and motion command bundles; the motion machine must accept every activate pulse
`default_nettype none

package car_pkg;

    ////////////////////////////////////////
    // Inputs from the buttons
    ////////////////////////////////////////

    // Buttons are active high while pressed
    typedef struct packed {
        floor_pkg::floor_mask_t call;
        floor_pkg::floor_mask_t panel;
        logic                   door_open;
        logic                   door_close;
        logic                   emergency;
        logic                   power;
    } button_in_t;

    // Reported by the motion machine
    typedef struct packed {
        floor_pkg::floor_t floor;
        logic              moving;
    } car_status_t;

    ////////////////////////////////////////
    // Command to the motion machine
    ////////////////////////////////////////

    // direction is one for up, activate is a single cycle pulse
    typedef struct packed {
        floor_pkg::floor_t target;
        logic              direction;
        logic              activate;
    } car_cmd_t;

endpackage

`default_nettype wire

//--- request_latch.sv
// Latches every pressed floor in one cycle; presses at the car floor and with power off or emergency are dropped
`default_nettype none
`timescale 1ns/1ps

module request_latch (
    input  wire logic                   clock,
    input  wire logic                   reset_n,
    input  wire car_pkg::button_in_t    buttons,
    input  wire car_pkg::car_status_t   status,
    output floor_pkg::floor_mask_t      call_lights,
    output floor_pkg::floor_mask_t      panel_lights
);

    floor_pkg::floor_mask_t here;
    floor_pkg::floor_mask_t arrive;
    floor_pkg::floor_mask_t press_call;
    floor_pkg::floor_mask_t press_panel;
    logic                   accept;

    // One hot mask of the floor the car is at
    always_comb begin
        here = '0;
        for (int i = 0; i < floor_pkg::num_floors; i++) begin
            here[i] = (int'(status.floor) == i);
        end
    end

    assign accept = buttons.power && !buttons.emergency;

    // Presses at the car floor never light
    assign press_call  = buttons.call & ~here & {floor_pkg::num_floors{accept}};
    assign press_panel = buttons.panel & ~here & {floor_pkg::num_floors{accept}};

    // Standing at a floor serves both of its lamps
    assign arrive = here & {floor_pkg::num_floors{!status.moving}};

    ////////////////////////////////////////
    // Lamp registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else begin
            call_lights  <= (call_lights | press_call) & ~arrive;
            panel_lights <= (panel_lights | press_panel) & ~arrive;
        end
    end

endmodule

`default_nettype wire

//--- floor_scan.sv
// Nearest pending floor strictly above (up) or below (down) the car, result one cycle after the lamps
`default_nettype none
`timescale 1ns/1ps

module floor_scan (
    input  wire logic                   clock,
    input  wire logic                   reset_n,
    input  wire floor_pkg::floor_mask_t call_lights,
    input  wire floor_pkg::floor_mask_t panel_lights,
    input  wire floor_pkg::floor_t      floor,
    input  wire logic                   direction,
    output logic                        found,
    output floor_pkg::floor_t           found_floor
);

    floor_pkg::floor_mask_t pending;
    logic                   pick_found;
    floor_pkg::floor_t      pick_floor;

    assign pending = call_lights | panel_lights;

    // Walk away from the car so the last hit is the nearest one
    always_comb begin
        pick_found = 1'b0;
        pick_floor = '0;
        if (direction) begin
            for (int i = floor_pkg::num_floors - 1; i >= 0; i--) begin
                if (pending[i] && (i > int'(floor))) begin
                    pick_found = 1'b1;
                    pick_floor = floor_pkg::floor_t'(i);
                end
            end
        end else begin
            for (int i = 0; i < floor_pkg::num_floors; i++) begin
                if (pending[i] && (i < int'(floor))) begin
                    pick_found = 1'b1;
                    pick_floor = floor_pkg::floor_t'(i);
                end
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            found <= 1'b0;
        end else begin
            found <= pick_found;
        end
    end

    // Only meaningful while found is high
    always_ff @(posedge clock) begin
        found_floor <= pick_floor;
    end

endmodule

`default_nettype wire

//--- sweep_timer.sv
// Counts consecutive enabled cycles; any low count_enable cycle restarts the wait from zero
`default_nettype none
`timescale 1ns/1ps

module sweep_timer (
    input  wire logic clock,
    input  wire logic reset_n,
    input  wire logic count_enable,
    output logic      expire
);

    logic [$clog2(floor_pkg::sweep_wait_cycles)-1:0] count;
    logic                                            at_limit;

    // True on the last enabled cycle of the wait
    assign at_limit = (count == $bits(count)'(floor_pkg::sweep_wait_cycles - 1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count  <= '0;
            expire <= 1'b0;
        end else if (!count_enable) begin
            count  <= '0;
            expire <= 1'b0;
        end else if (at_limit) begin
            count  <= '0;
            expire <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            expire <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- dispatch_fsm.sv
// Dispatches only from a standstill with power on and no emergency; travel ends when the car stops at the target
`default_nettype none
`timescale 1ns/1ps

module dispatch_fsm (
    input  wire logic                 clock,
    input  wire logic                 reset_n,
    input  wire car_pkg::button_in_t  buttons,
    input  wire car_pkg::car_status_t status,
    input  wire logic                 found,
    input  wire floor_pkg::floor_t    found_floor,
    input  wire logic                 expire,
    output logic                      count_enable,
    output car_pkg::car_cmd_t         cmd,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    typedef enum logic [1:0] {
        IDLE,
        DISPATCH,
        TRAVEL
    } state_t;

    state_t            state;
    floor_pkg::floor_t target;
    logic              direction;
    logic              go;
    logic              arrived;
    logic              door_open_q;
    logic              door_close_q;
    logic              stopped_on;

    ////////////////////////////////////////
    // Dispatch control
    ////////////////////////////////////////

    assign go = (state == IDLE) && found && !status.moving && buttons.power
                && !buttons.emergency && (found_floor != status.floor);

    assign arrived = !status.moving && (status.floor == target);

    // Idle time is only counted while the scan comes back empty
    assign count_enable = (state == IDLE) && !found;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state  <= IDLE;
            target <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (go) begin
                        target <= found_floor;
                        state  <= DISPATCH;
                    end
                end
                DISPATCH: state <= TRAVEL;
                TRAVEL: begin
                    if (arrived) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Sweep turns around when the idle wait runs out
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction <= 1'b1;
        end else if (expire) begin
            direction <= ~direction;
        end
    end

    assign cmd = '{target: target, direction: direction, activate: (state == DISPATCH)};

    ////////////////////////////////////////
    // Door permission
    ////////////////////////////////////////

    assign stopped_on = !status.moving && buttons.power;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_q  <= 1'b0;
            door_close_q <= 1'b0;
        end else begin
            door_open_q  <= buttons.door_open && stopped_on;
            door_close_q <= buttons.door_close && stopped_on;
        end
    end

    // Drop at once if the car starts or power fails
    assign door_open_allowed  = door_open_q && stopped_on;
    assign door_close_allowed = door_close_q && stopped_on;

endmodule

`default_nettype wire

//--- floor_logic_top.sv
// Request controller beside the motion FSM; activate follows a press by three cycles, no back-pressure
`default_nettype none
`timescale 1ns/1ps

module floor_logic_top (
    input  wire logic                 clock,
    input  wire logic                 reset_n,
    input  wire car_pkg::button_in_t  buttons,
    input  wire car_pkg::car_status_t status,
    output car_pkg::car_cmd_t         cmd,
    output floor_pkg::floor_mask_t    call_lights,
    output floor_pkg::floor_mask_t    panel_lights,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic              found;
    floor_pkg::floor_t found_floor;
    logic              count_enable;
    logic              expire;

    request_latch u_request_latch (
        .clock        (clock),
        .reset_n      (reset_n),
        .buttons      (buttons),
        .status       (status),
        .call_lights  (call_lights),
        .panel_lights (panel_lights)
    );

    // Scan follows the sweep direction held by the FSM
    floor_scan u_floor_scan (
        .clock        (clock),
        .reset_n      (reset_n),
        .call_lights  (call_lights),
        .panel_lights (panel_lights),
        .floor        (status.floor),
        .direction    (cmd.direction),
        .found        (found),
        .found_floor  (found_floor)
    );

    sweep_timer u_sweep_timer (
        .clock        (clock),
        .reset_n      (reset_n),
        .count_enable (count_enable),
        .expire       (expire)
    );

    dispatch_fsm u_dispatch_fsm (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .status             (status),
        .found              (found),
        .found_floor        (found_floor),
        .expire             (expire),
        .count_enable       (count_enable),
        .cmd                (cmd),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

//--- floor_logic_checker.sv
// Protocol assertions for floor_logic_top, sampled on the rising clock and masked while reset_n is low
`default_nettype none
`timescale 1ns/1ps

module floor_logic_checker (
    input wire logic                 clock,
    input wire logic                 reset_n,
    input wire car_pkg::button_in_t  buttons,
    input wire car_pkg::car_status_t status,
    input wire car_pkg::car_cmd_t    cmd,
    input wire logic                 door_open_allowed,
    input wire logic                 door_close_allowed
);

    // Number of failed assertions so far
    int failure_count = 0;

    ////////////////////////////////////////
    // Motion command
    ////////////////////////////////////////

    activate_single: assert property (@(posedge clock) disable iff (!reset_n)
        cmd.activate |=> !cmd.activate)
    else begin
        failure_count++;
        $error("activate stayed high for two cycles");
    end

    activate_powered: assert property (@(posedge clock) disable iff (!reset_n)
        cmd.activate |-> buttons.power)
    else begin
        failure_count++;
        $error("activate is high while power is off");
    end

    // A dispatch to the floor the car stands at would be a wasted move
    target_elsewhere: assert property (@(posedge clock) disable iff (!reset_n)
        cmd.activate |-> (cmd.target != status.floor))
    else begin
        failure_count++;
        $error("activate names the floor the car is already at");
    end

    ////////////////////////////////////////
    // Doors
    ////////////////////////////////////////

    // A cycle in motion or without power never grants a door in the next one
    doors_still: assert property (@(posedge clock) disable iff (!reset_n)
        (status.moving || !buttons.power) |=> !(door_open_allowed || door_close_allowed))
    else begin
        failure_count++;
        $error("a door permission follows a cycle in motion or without power");
    end

endmodule

bind floor_logic_top floor_logic_checker u_floor_logic_checker (
    .clock              (clock),
    .reset_n            (reset_n),
    .buttons            (buttons),
    .status             (status),
    .cmd                (cmd),
    .door_open_allowed  (door_open_allowed),
    .door_close_allowed (door_close_allowed)
);

`default_nettype wire

//--- tb_floor_logic.sv
// Runs from the project root so floor_logic_tests.txt is found; each row is sixteen hex words
`default_nettype none
`timescale 1ns/1ps

module tb_floor_logic;

    localparam int fields       = 16;
    localparam int num_rows     = 23;
    localparam int reset_cycles = 5;

    // Column positions within one row of the tests file
    localparam int f_call           = 0;
    localparam int f_panel          = 1;
    localparam int f_door_open      = 2;
    localparam int f_door_close     = 3;
    localparam int f_emergency      = 4;
    localparam int f_power          = 5;
    localparam int f_floor          = 6;
    localparam int f_moving         = 7;
    localparam int f_hold           = 8;
    localparam int f_exp_call       = 9;
    localparam int f_exp_panel      = 10;
    localparam int f_exp_target     = 11;
    localparam int f_exp_activate   = 12;
    localparam int f_exp_direction  = 13;
    localparam int f_exp_door_open  = 14;
    localparam int f_exp_door_close = 15;

    logic                   clock;
    logic                   reset_n;
    car_pkg::button_in_t    buttons;
    car_pkg::car_status_t   status;
    car_pkg::car_cmd_t      cmd;
    floor_pkg::floor_mask_t call_lights;
    floor_pkg::floor_mask_t panel_lights;
    logic                   door_open_allowed;
    logic                   door_close_allowed;

    logic [11:0] tests_mem [0:num_rows*fields-1];
    integer      seed;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    floor_logic_top u_floor_logic_top (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .status             (status),
        .cmd                (cmd),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Stops a stuck run and catches failed assertions of the bound checker
    always @(negedge clock) begin
        cycle_count++;
        if (u_floor_logic_top.u_floor_logic_checker.failure_count != 0) begin
            $display("A bound assertion failed, see the error above");
            $display("STATUS: FAIL");
            $fatal(1, "Assertion failure");
        end else if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run passed %0d cycles without finishing the test rows", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [11:0] row_word(input int row, input int idx);
        return tests_mem[row*fields + idx];
    endfunction

    task automatic check_value(input string what, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Row stimulus and checks
    ////////////////////////////////////////

    // Extra presses only touch lamps that are already lit, so results stay the same
    task automatic drive_row(input int row, input floor_pkg::floor_mask_t lit_call,
                             input floor_pkg::floor_mask_t lit_panel);
        logic [31:0] extra;
        extra = $random(seed);
        buttons.call       = row_word(row, f_call) | (extra[10:0] & lit_call);
        buttons.panel      = row_word(row, f_panel) | (extra[26:16] & lit_panel);
        buttons.door_open  = row_word(row, f_door_open) != 0;
        buttons.door_close = row_word(row, f_door_close) != 0;
        buttons.emergency  = row_word(row, f_emergency) != 0;
        buttons.power      = row_word(row, f_power) != 0;
        status.floor       = floor_pkg::floor_t'(row_word(row, f_floor));
        status.moving      = row_word(row, f_moving) != 0;
    endtask

    task automatic check_row(input int row);
        check_value($sformatf("row %0d call_lights", row), call_lights,
                    row_word(row, f_exp_call));
        check_value($sformatf("row %0d panel_lights", row), panel_lights,
                    row_word(row, f_exp_panel));
        check_value($sformatf("row %0d target", row), cmd.target,
                    row_word(row, f_exp_target));
        check_value($sformatf("row %0d activate", row), cmd.activate,
                    row_word(row, f_exp_activate));
        check_value($sformatf("row %0d direction", row), cmd.direction,
                    row_word(row, f_exp_direction));
        check_value($sformatf("row %0d door_open_allowed", row), door_open_allowed,
                    row_word(row, f_exp_door_open));
        check_value($sformatf("row %0d door_close_allowed", row), door_close_allowed,
                    row_word(row, f_exp_door_close));
    endtask

    initial begin
        int                     hold_total;
        floor_pkg::floor_mask_t lit_call;
        floor_pkg::floor_mask_t lit_panel;
        seed    = 32'h3d01_00eb;
        reset_n = 1'b0;
        buttons = '0;
        status  = '0;
        $readmemh("floor_logic_tests.txt", tests_mem);
        hold_total = 0;
        for (int r = 0; r < num_rows; r++) begin
            if ($isunknown(row_word(r, f_hold))) begin
                $display("Tests file is missing row %0d or has a bad hold count", r);
                $display("STATUS: FAIL");
                $fatal(1, "Bad tests file");
            end
            hold_total += int'(row_word(r, f_hold));
        end
        cycle_limit = 2 * (hold_total + reset_cycles);

        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset_n   = 1'b1;
        lit_call  = '0;
        lit_panel = '0;

        // Outputs are sampled on the falling edge that ends each hold
        for (int r = 0; r < num_rows; r++) begin
            drive_row(r, lit_call, lit_panel);
            repeat (int'(row_word(r, f_hold))) @(posedge clock);
            @(negedge clock);
            check_row(r);
            lit_call  = row_word(r, f_exp_call);
            lit_panel = row_word(r, f_exp_panel);
        end

        if (u_floor_logic_top.u_floor_logic_checker.failure_count != 0) begin
            $display("A bound assertion failed during the run");
            $display("STATUS: FAIL");
            $fatal(1, "Assertion failure");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- floor_logic_tests.txt
// call panel open close emerg power floor moving hold
//   exp_call exp_panel exp_target exp_activate exp_direction exp_door_open exp_door_close
010 000 0 0 0 0 3 0 2   000 000 0 0 1 0 0
000 020 0 0 1 1 3 0 1   000 000 0 0 1 0 0
04c 208 0 0 0 1 3 0 3   044 200 6 1 1 0 0
000 000 0 0 0 1 3 0 1   044 200 6 0 1 0 0
000 000 1 0 0 1 5 1 2   044 200 6 0 1 0 0
000 000 0 0 0 1 6 0 1   004 200 6 0 1 0 0
000 000 0 0 0 1 6 0 1   004 200 9 1 1 0 0
000 000 0 0 0 1 6 0 1   004 200 9 0 1 0 0
000 000 0 0 0 1 8 1 1   004 200 9 0 1 0 0
000 000 0 0 0 1 9 0 1   004 000 9 0 1 0 0
000 000 0 0 0 1 9 0 b   004 000 9 0 1 0 0
000 000 0 0 0 1 9 0 1   004 000 9 0 0 0 0
000 000 0 0 0 1 9 0 1   004 000 9 0 0 0 0
000 000 0 0 0 1 9 0 1   004 000 2 1 0 0 0
000 000 0 0 0 1 9 0 1   004 000 2 0 0 0 0
000 000 0 0 0 1 5 1 1   004 000 2 0 0 0 0
000 000 0 0 0 1 2 0 1   000 000 2 0 0 0 0
000 000 1 0 0 1 2 0 1   000 000 2 0 0 1 0
000 000 0 1 0 1 2 0 1   000 000 2 0 0 0 1
000 000 1 1 0 0 2 0 1   000 000 2 0 0 0 0
000 000 1 1 0 1 2 1 1   000 000 2 0 0 0 0
000 000 1 0 0 1 2 0 2   000 000 2 0 0 1 0
000 000 1 0 0 1 2 1 1   000 000 2 0 0 0 0

//--- verilog.f
floor_pkg.sv
car_pkg.sv
request_latch.sv
floor_scan.sv
sweep_timer.sv
dispatch_fsm.sv
floor_logic_top.sv
floor_logic_checker.sv
tb_floor_logic.sv
